/* logic/isa_pkg.sv */
//////////////////////////////
// rv32i instruction formats
// opcode and funct codes
// union view of one instruction word
//////////////////////////////

package isa_pkg;

  //////////////////////////////
  // opcodes
  //////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register alu group
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register-immediate alu group

  //////////////////////////////
  // funct codes
  //////////////////////////////

  localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, addi
  localparam logic [2:0] F3_SLL  = 3'b001; // sll, slli
  localparam logic [2:0] F3_SLT  = 3'b010; // signed compare
  localparam logic [2:0] F3_SLTU = 3'b011; // unsigned compare
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101; // srl and sra share this
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000; // normal form
  localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

  //////////////////////////////
  // formats
  //////////////////////////////

  typedef struct packed {
    logic [6:0] funct7; // [31:25]
    logic [4:0] rs2;    // [24:20]
    logic [4:0] rs1;    // [19:15]
    logic [2:0] funct3; // [14:12]
    logic [4:0] rd;     // [11:7]
    logic [6:0] opcode; // [6:0]
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm12;  // signed immediate, shamt in low bits
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // same 32 bits read as r-type or i-type
  typedef union packed {
    instr_r_t rtype;
    instr_i_t itype;
  } instr_u;

endpackage

/* logic/core_pkg.sv */
//////////////////////////////
// register file sizes
// alu operation codes
// control and write-back structs
//////////////////////////////

package core_pkg;

  localparam int XLEN    = 32;              // register width
  localparam int NUM_REG = 32;              // x0..x31
  localparam int REG_AW  = $clog2(NUM_REG); // 5 address bits
  localparam int SHAMT_W = $clog2(XLEN);    // shift amount bits

  //////////////////////////////
  // alu operations
  //////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,  // signed less-than
    ALU_SLTU = 4'd4,  // unsigned less-than
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,  // keeps sign bit
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  //////////////////////////////
  // structs between blocks
  //////////////////////////////

  typedef struct packed {
    logic              valid;   // instruction strobe
    logic              illegal; // opcode or funct not supported
    logic              we;      // writes a register, never x0
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic              use_imm; // immediate replaces rs2
    logic [XLEN-1:0]   imm;     // sign-extended imm12
    alu_op_e           alu_op;
  } ctrl_t;

  typedef struct packed {
    logic              valid;   // one cycle after the strobe
    logic              illegal;
    logic [REG_AW-1:0] rd;      // zero when nothing is written
    logic [XLEN-1:0]   data;
  } wb_t;

endpackage

/* logic/exec_ctrl.sv */
//////////////////////////////
// control block decoding one
// instruction into ctrl_t
//////////////////////////////

`timescale 1ns/10ps

module exec_ctrl (
  input  logic            instr_valid_i, // one-cycle instruction strobe
  input  isa_pkg::instr_u instr_i,       // raw instruction word
  output core_pkg::ctrl_t ctrl_o         // combinational decoded control
);

  //////////////////////////////
  // signals
  //////////////////////////////

  logic                      is_op;     // register-register group
  logic                      is_op_imm; // register-immediate group
  logic                      bad_funct; // funct combination not listed
  logic                      illegal;
  logic                      we;
  logic [2:0]                funct3;    // same bits in both views
  logic [6:0]                imm_hi;    // imm12[11:5] checked on shifts
  logic [core_pkg::XLEN-1:0] imm_sext;
  core_pkg::alu_op_e         alu_op;

  // plain funct3 mapping for all base forms
  function automatic core_pkg::alu_op_e base_op(input logic [2:0] f3);
    case (f3)
      isa_pkg::F3_ADD:  return core_pkg::ALU_ADD;
      isa_pkg::F3_SLL:  return core_pkg::ALU_SLL;
      isa_pkg::F3_SLT:  return core_pkg::ALU_SLT;
      isa_pkg::F3_SLTU: return core_pkg::ALU_SLTU;
      isa_pkg::F3_XOR:  return core_pkg::ALU_XOR;
      isa_pkg::F3_SRL:  return core_pkg::ALU_SRL;
      isa_pkg::F3_OR:   return core_pkg::ALU_OR;
      isa_pkg::F3_AND:  return core_pkg::ALU_AND;
      default:          return core_pkg::ALU_ADD;
    endcase
  endfunction

  //////////////////////////////
  // field extraction
  //////////////////////////////

  assign is_op     = (instr_i.rtype.opcode == isa_pkg::OPC_OP);
  assign is_op_imm = (instr_i.itype.opcode == isa_pkg::OPC_OP_IMM);
  assign funct3    = instr_i.rtype.funct3;
  assign imm_hi    = instr_i.itype.imm12[11:5];
  assign imm_sext  = {{(core_pkg::XLEN-12){instr_i.itype.imm12[11]}}, instr_i.itype.imm12};

  //////////////////////////////
  // funct decode
  //////////////////////////////

  always_comb begin
    alu_op    = base_op(funct3);
    bad_funct = 1'b0;
    if (is_op) begin
      if (instr_i.rtype.funct7 == isa_pkg::F7_ALT) begin
        case (funct3)
          isa_pkg::F3_ADD: alu_op = core_pkg::ALU_SUB;
          isa_pkg::F3_SRL: alu_op = core_pkg::ALU_SRA;
          default:         bad_funct = 1'b1; // no alt form
        endcase
      end else if (instr_i.rtype.funct7 != isa_pkg::F7_BASE) begin
        bad_funct = 1'b1;
      end
    end else if (is_op_imm) begin
      if (funct3 == isa_pkg::F3_SLL) begin
        bad_funct = (imm_hi != isa_pkg::F7_BASE); // slli only
      end else if (funct3 == isa_pkg::F3_SRL) begin
        if (imm_hi == isa_pkg::F7_ALT) begin
          alu_op = core_pkg::ALU_SRA; // srai
        end else if (imm_hi != isa_pkg::F7_BASE) begin
          bad_funct = 1'b1;
        end
      end
    end
  end

  assign illegal = instr_valid_i & (~(is_op | is_op_imm) | bad_funct);
  assign we      = instr_valid_i & ~illegal & (instr_i.rtype.rd != '0); // x0 never written

  //////////////////////////////
  // output
  //////////////////////////////

  assign ctrl_o = '{
    valid:   instr_valid_i,
    illegal: illegal,
    we:      we,
    rd:      instr_i.rtype.rd,
    rs1:     instr_i.rtype.rs1,
    rs2:     instr_i.rtype.rs2,  // holds imm bits on i-type
    use_imm: is_op_imm,
    imm:     imm_sext,
    alu_op:  alu_op
  };

endmodule

/* logic/reg_file.sv */
//////////////////////////////
// 32-entry register file
// two read ports, one write port
//////////////////////////////

`timescale 1ns/10ps

module reg_file (
  input  logic                        clk_i,      // core clock
  input  logic                        rst_n_i,    // sync active-low reset
  input  logic [core_pkg::REG_AW-1:0] rs1_addr_i, // source 1 address
  input  logic [core_pkg::REG_AW-1:0] rs2_addr_i, // source 2 address
  input  core_pkg::wb_t               wr_i,       // write-back stage
  output logic [core_pkg::XLEN-1:0]   rs1_data_o, // source 1 data
  output logic [core_pkg::XLEN-1:0]   rs2_data_o  // source 2 data
);

  //////////////////////////////
  // storage
  //////////////////////////////

  logic [core_pkg::NUM_REG-1:1][core_pkg::XLEN-1:0] regs_q; // x1..x31 with no x0 storage
  logic                                              wr_en;

  // rd is already zero when the instruction does not write
  assign wr_en = wr_i.valid & ~wr_i.illegal & (wr_i.rd != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      regs_q <= '0; // all registers start at zero
    end else if (wr_en) begin
      regs_q[wr_i.rd] <= wr_i.data;
    end
  end

  //////////////////////////////
  // read muxes
  //////////////////////////////

  always_comb begin
    rs1_data_o = '0; // x0 reads zero
    rs2_data_o = '0;
    if (rs1_addr_i != '0) begin
      rs1_data_o = regs_q[rs1_addr_i];
    end
    if (rs2_addr_i != '0) begin
      rs2_data_o = regs_q[rs2_addr_i];
    end
  end

  a_write_reads_back: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      wr_en |=>
        ((rs1_addr_i != $past(wr_i.rd)) || (rs1_data_o == $past(wr_i.data))) &&
        ((rs2_addr_i != $past(wr_i.rd)) || (rs2_data_o == $past(wr_i.data)))
  ) else $error("reg_file: read after write returned stale data");

endmodule

/* logic/alu.sv */
//////////////////////////////
// alu operations and the
// registered write-back stage
//////////////////////////////

`timescale 1ns/10ps

module alu (
  input  logic                      clk_i,      // core clock
  input  logic                      rst_n_i,    // sync active-low reset
  input  core_pkg::ctrl_t           ctrl_i,     // from exec_ctrl
  input  logic [core_pkg::XLEN-1:0] rs1_data_i, // first operand
  input  logic [core_pkg::XLEN-1:0] rs2_data_i, // second operand unless imm
  output core_pkg::wb_t             wb_o        // write-back one cycle later
);

  //////////////////////////////
  // operands and result
  //////////////////////////////

  logic [core_pkg::XLEN-1:0]    op_b;   // rs2 or immediate
  logic [core_pkg::SHAMT_W-1:0] shamt;  // low 5 bits only
  logic [core_pkg::XLEN-1:0]    result;

  logic                         valid_q;
  logic                         illegal_q;
  logic [core_pkg::REG_AW-1:0]  rd_q;
  logic [core_pkg::XLEN-1:0]    data_q;

  assign op_b  = ctrl_i.use_imm ? ctrl_i.imm : rs2_data_i;
  assign shamt = op_b[core_pkg::SHAMT_W-1:0];

  always_comb begin
    case (ctrl_i.alu_op)
      core_pkg::ALU_ADD:  result = rs1_data_i + op_b;
      core_pkg::ALU_SUB:  result = rs1_data_i - op_b;
      core_pkg::ALU_SLL:  result = rs1_data_i << shamt;
      core_pkg::ALU_SLT:  result = {31'd0, $signed(rs1_data_i) < $signed(op_b)};
      core_pkg::ALU_SLTU: result = {31'd0, rs1_data_i < op_b};
      core_pkg::ALU_XOR:  result = rs1_data_i ^ op_b;
      core_pkg::ALU_SRL:  result = rs1_data_i >> shamt;
      core_pkg::ALU_SRA:  result = $unsigned($signed(rs1_data_i) >>> shamt); // sign fill
      core_pkg::ALU_OR:   result = rs1_data_i | op_b;
      core_pkg::ALU_AND:  result = rs1_data_i & op_b;
      default:            result = '0;
    endcase
  end

  //////////////////////////////
  // write-back register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q   <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      valid_q   <= ctrl_i.valid;   // illegal words pulse valid too
      illegal_q <= ctrl_i.illegal;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_q   <= ctrl_i.we ? ctrl_i.rd : '0;        // x0 when nothing written
    data_q <= ctrl_i.illegal ? '0 : result;      // no stray data on illegal
  end

  assign wb_o = '{valid: valid_q, illegal: illegal_q, rd: rd_q, data: data_q};

  a_illegal_no_rd: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      ctrl_i.illegal |=> (wb_o.rd == '0)
  ) else $error("alu: write-back rd set for an illegal instruction");

endmodule

/* logic/exec_top.sv */
//////////////////////////////
// execute slice top level
//////////////////////////////

`timescale 1ns/10ps

module exec_top (
  input  logic            clk_i,         // core clock
  input  logic            rst_n_i,       // sync reset, active low
  input  logic            instr_valid_i, // one-cycle instruction strobe
  input  isa_pkg::instr_u instr_i,       // instruction word
  output core_pkg::wb_t   wb_o           // write-back port
);

  //////////////////////////////
  // wires
  //////////////////////////////

  core_pkg::ctrl_t           ctrl;     // decoded control
  logic [core_pkg::XLEN-1:0] rs1_data;
  logic [core_pkg::XLEN-1:0] rs2_data;

  //////////////////////////////
  // instances
  //////////////////////////////

  exec_ctrl u_exec_ctrl (
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .ctrl_o       (ctrl)
  );

  reg_file u_reg_file (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .rs1_addr_i(ctrl.rs1),
    .rs2_addr_i(ctrl.rs2),
    .wr_i      (wb_o),     // write port fed from registered stage
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data)
  );

  alu u_alu (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ctrl_i    (ctrl),
    .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data),
    .wb_o      (wb_o)
  );

endmodule

/* test/tb_clock.sv */
//////////////////////////////
// testbench clock source
// 8 ns period, starts low
//////////////////////////////

`timescale 1ns/10ps

module tb_clock (
  output logic clk_o // free-running clock
);

  localparam real HALF_NS = 4.0; // half of the 8 ns period

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o; // toggle every half period
  end

endmodule

/* test/exec_tb.sv */
//////////////////////////////
// testbench for exec_top
// pattern file driven, one line per test
//////////////////////////////

`timescale 1ns/10ps

module exec_tb;

  localparam int TIMEOUT_CYC = 20;  // max cycles to wait for write-back
  localparam int MAX_LINES   = 512; // guard on the pattern file reader

  logic            clk_i;
  logic            rst_n_i;
  logic            instr_valid_i;
  isa_pkg::instr_u instr_i;
  core_pkg::wb_t   wb_o;

  // one entry per pattern line
  string                       names[$];
  logic [31:0]                 words[$];
  bit                          exp_we[$];
  bit                          exp_ill[$];
  logic [core_pkg::REG_AW-1:0] exp_rd[$];
  logic [core_pkg::XLEN-1:0]   exp_data[$];
  bit                          b2b[$]; // strobed right after the previous line

  int pass_cnt;
  int fail_cnt;
  bit test_ok;  // cleared by any mismatch in the current test
  bit aborted;  // timeout or missing pattern file

  tb_clock u_clock (.clk_o(clk_i));

  exec_top UUT (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .wb_o         (wb_o)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic check_val(input string test, input string field,
                           input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch %s %s: expected %h, actual %h", test, field, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic tally(input string test);
    if (test_ok) begin
      pass_cnt++;
      $display("PASS %s", test);
    end else begin
      fail_cnt++;
      $display("FAIL %s", test);
    end
  endtask

  task automatic load_patterns();
    int    fd;
    int    rc;
    int    lines;
    string line;
    string nm;
    logic [31:0] w;
    logic [31:0] d;
    int    we;
    int    il;
    int    rd;
    int    bb;
    fd    = $fopen("test/exec_patterns.txt", "r");
    lines = 0;
    if (fd == 0) begin
      $display("Could not open pattern file test/exec_patterns.txt");
      aborted = 1'b1;
      return;
    end
    while (!$feof(fd) && lines < MAX_LINES) begin
      lines++;
      line = "";
      rc   = $fgets(line, fd);
      if (line.len() == 0 || line.getc(0) == "#") continue; // blank or column notes
      rc = $sscanf(line, "%s %h %d %d %d %h %d", nm, w, we, il, rd, d, bb);
      if (rc == 7) begin
        names.push_back(nm);
        words.push_back(w);
        exp_we.push_back(we != 0);
        exp_ill.push_back(il != 0);
        exp_rd.push_back(rd[core_pkg::REG_AW-1:0]);
        exp_data.push_back(d);
        b2b.push_back(bb != 0);
      end
    end
    $fclose(fd);
  endtask

  // strobe one word on the rising edge
  task automatic drive_instr(input logic [31:0] word);
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    instr_i       <= word;
  endtask

  task automatic drive_idle();
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    instr_i       <= '0;
  endtask

  // sample on the falling edge, where wb_o is stable
  task automatic wait_wb(output int cycles, output bit seen);
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < TIMEOUT_CYC) begin
      @(negedge clk_i);
      cycles++;
      seen = wb_o.valid;
    end
  endtask

  task automatic timeout_fail(input string test);
    $display("Timeout: no write-back for %s within %0d cycles", test, TIMEOUT_CYC);
    fail_cnt++;
    aborted = 1'b1;
  endtask

  task automatic check_result(input int idx, input int cycles);
    bit act_we;
    test_ok = 1'b1;
    act_we  = wb_o.valid && !wb_o.illegal && (wb_o.rd != '0); // register write seen at port
    if (cycles != 1) begin
      $display("%s: write-back came %0d cycles after the strobe, not 1", names[idx], cycles);
      test_ok = 1'b0;
    end
    check_val(names[idx], "we", exp_we[idx], act_we);
    check_val(names[idx], "illegal", exp_ill[idx], wb_o.illegal);
    check_val(names[idx], "rd", exp_rd[idx], wb_o.rd);
    check_val(names[idx], "data", exp_data[idx], wb_o.data);
    tally(names[idx]);
  endtask

  task automatic run_single(input int idx);
    int cycles;
    bit seen;
    drive_instr(words[idx]);
    drive_idle();
    wait_wb(cycles, seen);
    if (!seen) begin
      timeout_fail(names[idx]);
      return;
    end
    check_result(idx, cycles);
  endtask

  // two independent words on consecutive edges
  task automatic run_pair(input int idx);
    int cycles;
    bit seen;
    drive_instr(words[idx]);
    drive_instr(words[idx+1]);
    wait_wb(cycles, seen);
    if (!seen) begin
      timeout_fail(names[idx]);
      return;
    end
    check_result(idx, cycles);
    drive_idle();
    wait_wb(cycles, seen); // second result must follow on the next cycle
    if (!seen) begin
      timeout_fail(names[idx+1]);
      return;
    end
    check_result(idx + 1, cycles);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int i;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    aborted       = 1'b0;
    load_patterns();
    for (i = 0; i < 2; i++) begin
      @(posedge clk_i); // reset held for two cycles
    end
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    test_ok = 1'b1;
    check_val("reset_idle", "valid", 32'd0, wb_o.valid);
    tally("reset_idle");
    if (!aborted && names.size() == 0) begin
      $display("No tests found in the pattern file");
      aborted = 1'b1;
    end
    i = 0;
    while (!aborted && i < names.size()) begin
      if (i + 1 < names.size() && b2b[i+1]) begin
        run_pair(i);
        i += 2;
      end else begin
        run_single(i);
        i += 1;
      end
    end
    $display("Totals: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && !aborted) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* test/exec_patterns.txt */
# name  instr  we  illegal  rd  data  b2b
# instr and data in hex, rd in decimal, b2b 1 strobes the line on the cycle after the one before
# every other line follows an idle cycle, so a dependent instruction reads the written value
addi_x1_pos      00500093 1 0 1  00000005 0
addi_x2_neg      FFD00113 1 0 2  FFFFFFFD 0
addi_x3_max      7FF00193 1 0 3  000007FF 0
addi_x4_min      80000213 1 0 4  FFFFF800 0
read_x1          00100533 1 0 10 00000005 0
read_x2          00200533 1 0 10 FFFFFFFD 0
read_x3          00300533 1 0 10 000007FF 0
read_x4          00400533 1 0 10 FFFFF800 0
add_x1_x2        002085B3 1 0 11 00000002 0
sub_x1_x2        402085B3 1 0 11 00000008 0
and_x1_x2        0020F5B3 1 0 11 00000005 0
or_x1_x2         0020E5B3 1 0 11 FFFFFFFD 0
xor_x1_x2        0020C5B3 1 0 11 FFFFFFF8 0
slt_pos_neg      0020A5B3 1 0 11 00000000 0
sltu_pos_neg     0020B5B3 1 0 11 00000001 0
slt_neg_pos      001125B3 1 0 11 00000001 0
sltu_neg_pos     001135B3 1 0 11 00000000 0
sub_x3_x4        404185B3 1 0 11 00000FFF 0
addi_x6_shamt    02400313 1 0 6  00000024 0
sll_x3_x6        00619633 1 0 12 00007FF0 0
srl_x4_x6        00625633 1 0 12 0FFFFF80 0
sra_x4_x6        40625633 1 0 12 FFFFFF80 0
slli_x3_31       01F19613 1 0 12 80000000 0
srli_x4_8        00825613 1 0 12 00FFFFF8 0
srai_x4_8        40825613 1 0 12 FFFFFFF8 0
addi_x0_dropped  00708013 0 0 0  0000000C 0
read_x0          000006B3 1 0 13 00000000 0
lui_illegal      123450B7 0 1 0  00000000 0
read_x1_kept     001006B3 1 0 13 00000005 0
add_bad_funct7   02108133 0 1 0  00000000 0
read_x2_kept     002006B3 1 0 13 FFFFFFFD 0
slli_bad_imm     40119613 0 1 0  00000000 0
read_x12_kept    00C006B3 1 0 13 FFFFFFF8 0
addi_x14_first   06400713 1 0 14 00000064 0
addi_x15_second  FFF00793 1 0 15 FFFFFFFF 1
add_x14_x15      00F706B3 1 0 13 00000063 0
sub_x3_x1_first  40118833 1 0 16 000007FA 0
or_x1_x3_second  0030E8B3 1 0 17 000007FF 1
read_x16         010006B3 1 0 13 000007FA 0
read_x17         011006B3 1 0 13 000007FF 0

/* sources.f */
logic/isa_pkg.sv
logic/core_pkg.sv
logic/exec_ctrl.sv
logic/reg_file.sv
logic/alu.sv
logic/exec_top.sv
test/tb_clock.sv
test/exec_tb.sv
